/* logic/iq_upconv_pkg.sv */
package iq_upconv_pkg;

  // Quarter-wave table geometry.
  localparam int LUT_SIZE = 16;
  localparam int PHASE_W  = $clog2(4 * LUT_SIZE);
  localparam int QTR_W    = $clog2(LUT_SIZE);

  // Signed datapath widths.
  localparam int LUT_W    = 12;
  localparam int DATA_W   = 12;
  localparam int OUT_W    = 12;
  localparam int PROD_W   = DATA_W + LUT_W;

  localparam real PI      = 3.14159265358979323846;

  // Quarter of the full sine period, top two phase bits.
  typedef enum logic [1:0] {
    QUAD_0,
    QUAD_1,
    QUAD_2,
    QUAD_3
  } quadrant_e;

  typedef logic signed [LUT_W-1:0] lut_t [LUT_SIZE];

  // First quarter of a sine period, sampled at half-step offsets.
  // The offset keeps the mirrored quarters symmetric without a shared entry.
  function automatic lut_t quarter_sine_lut();
    lut_t lut;
    real  amp;
    real  angle;
    real  value;
    amp = (2.0 ** (LUT_W - 1)) - 1.0;
    for (int k = 0; k < LUT_SIZE; k++) begin
      angle  = 2.0 * PI * (k + 0.5) / (4.0 * LUT_SIZE);
      value  = $sin(angle) * amp;
      lut[k] = LUT_W'($rtoi(value + 0.5));  // All entries positive.
    end
    return lut;
  endfunction

endpackage

/* logic/sin_cos_iq_gen.sv */
`timescale 1ns/1ps

module sin_cos_iq_gen import iq_upconv_pkg::*; (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     en,
  input  logic signed [DATA_W-1:0] i_data,
  input  logic signed [DATA_W-1:0] q_data,
  output logic                     gen_valid,
  output logic signed [LUT_W-1:0]  gen_sin,
  output logic signed [LUT_W-1:0]  gen_cos,
  output logic signed [DATA_W-1:0] gen_i,
  output logic signed [DATA_W-1:0] gen_q
);

  lut_t                    sine_lut;
  logic [PHASE_W-1:0]      phase;
  logic [PHASE_W-1:0]      cos_phase;
  quadrant_e               sin_quad;
  quadrant_e               cos_quad;
  logic [QTR_W-1:0]        sin_idx;
  logic [QTR_W-1:0]        cos_idx;
  logic signed [LUT_W-1:0] sin_val;
  logic signed [LUT_W-1:0] cos_val;

  assign sine_lut  = quarter_sine_lut();
  assign cos_phase = phase + PHASE_W'(LUT_SIZE);  // One quarter ahead.

  // Quadrant from the top bits, table index from the low bits.
  function automatic void decode_phase(
    input  logic [PHASE_W-1:0] p,
    output quadrant_e          quad,
    output logic [QTR_W-1:0]   idx
  );
    quad = quadrant_e'(p[PHASE_W-1:QTR_W]);
    unique case (quad)
      QUAD_0, QUAD_2: idx = p[QTR_W-1:0];
      QUAD_1, QUAD_3: idx = ~p[QTR_W-1:0];  // Falling quarter, read backwards.
    endcase
  endfunction

  // Second half of the period is the negated first half.
  function automatic logic signed [LUT_W-1:0] apply_sign(
    input quadrant_e               quad,
    input logic signed [LUT_W-1:0] entry
  );
    logic signed [LUT_W-1:0] result;
    unique case (quad)
      QUAD_0, QUAD_1: result = entry;
      QUAD_2, QUAD_3: result = -entry;
    endcase
    return result;
  endfunction

  always_comb begin
    decode_phase(phase, sin_quad, sin_idx);
    decode_phase(cos_phase, cos_quad, cos_idx);
    sin_val = apply_sign(sin_quad, sine_lut[sin_idx]);
    cos_val = apply_sign(cos_quad, sine_lut[cos_idx]);
  end

  // Phase steps once per accepted sample.
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      phase <= '0;
    end else if (en) begin
      phase <= phase + 1'b1;  // Natural wrap at the full period.
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      gen_valid <= 1'b0;
      gen_sin   <= '0;
      gen_cos   <= '0;
      gen_i     <= '0;
      gen_q     <= '0;
    end else begin
      gen_valid <= en;
      if (en) begin
        gen_sin <= sin_val;
        gen_cos <= cos_val;
        gen_i   <= i_data;  // Sample stays aligned with its phase.
        gen_q   <= q_data;
      end
    end
  end

endmodule

/* logic/iq_mixer.sv */
`timescale 1ns/1ps

module iq_mixer import iq_upconv_pkg::*; (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     gen_valid,
  input  logic signed [LUT_W-1:0]  gen_sin,
  input  logic signed [LUT_W-1:0]  gen_cos,
  input  logic signed [DATA_W-1:0] gen_i,
  input  logic signed [DATA_W-1:0] gen_q,
  output logic                     mix_valid,
  output logic signed [PROD_W-1:0] prod_ic,
  output logic signed [PROD_W-1:0] prod_qs
);

  logic signed [PROD_W-1:0] ic_full;
  logic signed [PROD_W-1:0] qs_full;

  // Full precision products, no truncation here.
  assign ic_full = gen_i * gen_cos;
  assign qs_full = gen_q * gen_sin;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      mix_valid <= 1'b0;
    end else begin
      mix_valid <= gen_valid;
    end
  end

  // Products hold their value through idle cycles.
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      prod_ic <= '0;
      prod_qs <= '0;
    end else if (gen_valid) begin
      prod_ic <= ic_full;
      prod_qs <= qs_full;
    end
  end

endmodule

/* logic/if_combiner.sv */
`timescale 1ns/1ps

module if_combiner import iq_upconv_pkg::*; (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     mix_valid,
  input  logic signed [PROD_W-1:0] prod_ic,
  input  logic signed [PROD_W-1:0] prod_qs,
  output logic                     if_valid,
  output logic signed [OUT_W-1:0]  if_data
);

  logic signed [PROD_W:0]  diff;
  logic signed [PROD_W:0]  rounded;
  logic signed [PROD_W:0]  scaled;
  logic                    in_range;
  logic signed [OUT_W-1:0] clamped;

  always_comb begin
    diff    = prod_ic - prod_qs;  // One guard bit for the subtraction.
    rounded = diff + (PROD_W + 1)'(2 ** (LUT_W - 2));
    scaled  = rounded >>> (LUT_W - 1);
    // Fits when all bits above the output sign match it.
    in_range = (&scaled[PROD_W:OUT_W-1]) || !(|scaled[PROD_W:OUT_W-1]);
    if (in_range) begin
      clamped = scaled[OUT_W-1:0];
    end else if (scaled[PROD_W]) begin
      clamped = {1'b1, {(OUT_W - 1){1'b0}}};  // Most negative.
    end else begin
      clamped = {1'b0, {(OUT_W - 1){1'b1}}};  // Most positive.
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      if_valid <= 1'b0;
      if_data  <= '0;
    end else begin
      if_valid <= mix_valid;
      if (mix_valid) begin
        if_data <= clamped;
      end
    end
  end

endmodule

/* logic/iq_upconverter.sv */
`timescale 1ns/1ps

module iq_upconverter import iq_upconv_pkg::*; (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     en,
  input  logic signed [DATA_W-1:0] i_data,
  input  logic signed [DATA_W-1:0] q_data,
  output logic                     if_valid,
  output logic signed [OUT_W-1:0]  if_data
);

  // Generator to mixer.
  logic                     gen_valid;
  logic signed [LUT_W-1:0]  gen_sin;
  logic signed [LUT_W-1:0]  gen_cos;
  logic signed [DATA_W-1:0] gen_i;
  logic signed [DATA_W-1:0] gen_q;

  // Mixer to combiner.
  logic                     mix_valid;
  logic signed [PROD_W-1:0] prod_ic;
  logic signed [PROD_W-1:0] prod_qs;

  sin_cos_iq_gen gen_i0 (
    .clk       (clk),
    .rstn      (rstn),
    .en        (en),
    .i_data    (i_data),
    .q_data    (q_data),
    .gen_valid (gen_valid),
    .gen_sin   (gen_sin),
    .gen_cos   (gen_cos),
    .gen_i     (gen_i),
    .gen_q     (gen_q)
  );

  iq_mixer mixer_i (
    .clk       (clk),
    .rstn      (rstn),
    .gen_valid (gen_valid),
    .gen_sin   (gen_sin),
    .gen_cos   (gen_cos),
    .gen_i     (gen_i),
    .gen_q     (gen_q),
    .mix_valid (mix_valid),
    .prod_ic   (prod_ic),
    .prod_qs   (prod_qs)
  );

  if_combiner combiner_i (
    .clk       (clk),
    .rstn      (rstn),
    .mix_valid (mix_valid),
    .prod_ic   (prod_ic),
    .prod_qs   (prod_qs),
    .if_valid  (if_valid),
    .if_data   (if_data)
  );

endmodule

/* tests/iq_upconverter_checker.sv */
`timescale 1ns/1ps

module iq_upconverter_checker import iq_upconv_pkg::*; (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     en,
  input  logic signed [DATA_W-1:0] i_data,
  input  logic signed [DATA_W-1:0] q_data,
  input  logic                     if_valid,
  input  logic signed [OUT_W-1:0]  if_data,
  output int                       value_errors,
  output int                       protocol_errors,
  output int                       outstanding
);

  localparam int PERIOD  = 4 * LUT_SIZE;
  localparam int LATENCY = 3;
  localparam int OUT_MAX = 2 ** (OUT_W - 1) - 1;
  localparam int OUT_MIN = -(2 ** (OUT_W - 1));

  int model_phase;
  int cycle;
  bit seen_en;
  int exp_data_q[$];
  int exp_cycle_q[$];
  int exp_val;
  int exp_cyc;

  // Entry k of the first quarter at a half-step offset.
  function automatic int table_entry(input int k);
    real amp;
    real angle;
    amp   = (2.0 ** (LUT_W - 1)) - 1.0;
    angle = 2.0 * PI * (k + 0.5) / (4.0 * LUT_SIZE);
    return int'($sin(angle) * amp);  // Real to int rounds to nearest.
  endfunction

  // Full period sine built from the quarter table.
  function automatic int sine_ref(input int p);
    if (p < LUT_SIZE) begin
      return table_entry(p);
    end else if (p < 2 * LUT_SIZE) begin
      return table_entry(2 * LUT_SIZE - 1 - p);
    end else if (p < 3 * LUT_SIZE) begin
      return -table_entry(p - 2 * LUT_SIZE);
    end
    return -table_entry(4 * LUT_SIZE - 1 - p);
  endfunction

  // Rounded, scaled and clamped I*cos - Q*sin.
  function automatic int expected_if(input int i_val, input int q_val, input int p);
    longint diff;
    longint scaled;
    diff   = longint'(i_val) * sine_ref((p + LUT_SIZE) % PERIOD)
           - longint'(q_val) * sine_ref(p);
    scaled = (diff + (longint'(1) <<< (LUT_W - 2))) >>> (LUT_W - 1);
    if (scaled > OUT_MAX) begin
      return OUT_MAX;
    end else if (scaled < OUT_MIN) begin
      return OUT_MIN;
    end
    return int'(scaled);
  endfunction

  initial begin
    value_errors    = 0;
    protocol_errors = 0;
    outstanding     = 0;
  end

  always @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      model_phase = 0;
      cycle       = 0;
      seen_en     = 1'b0;
      exp_data_q.delete();
      exp_cycle_q.delete();
      outstanding = 0;
    end else begin
      if (if_valid === 1'b1) begin
        if (exp_data_q.size() == 0) begin
          protocol_errors++;
          $display("if_valid went high at %0.1f ns with no sample in flight", $realtime);
        end else begin
          exp_val = exp_data_q.pop_front();
          exp_cyc = exp_cycle_q.pop_front();
          if (cycle - exp_cyc != LATENCY) begin
            protocol_errors++;
            $display("if_valid came %0d cycles after its en instead of %0d, at %0.1f ns",
                     cycle - exp_cyc, LATENCY, $realtime);
          end
          if (if_data !== OUT_W'(exp_val)) begin
            value_errors++;
            $display("Error at %0.1f ns: if_data expected %0d, got %0d",
                     $realtime, exp_val, if_data);
          end
        end
      end else begin
        if (if_valid !== 1'b0) begin
          protocol_errors++;
          $display("if_valid is unknown at %0.1f ns", $realtime);
        end
        // Drop an overdue sample so it is reported once.
        if (exp_cycle_q.size() != 0 && cycle - exp_cycle_q[0] >= LATENCY) begin
          protocol_errors++;
          $display("if_valid missing for a sample accepted at cycle %0d, at %0.1f ns",
                   exp_cycle_q[0], $realtime);
          void'(exp_data_q.pop_front());
          void'(exp_cycle_q.pop_front());
        end
        if (!seen_en && if_data !== '0) begin
          value_errors++;
          $display("Error at %0.1f ns: if_data expected 0, got %0d", $realtime, if_data);
        end
      end
      if (en === 1'b1) begin
        exp_data_q.push_back(expected_if(i_data, q_data, model_phase));
        exp_cycle_q.push_back(cycle);
        model_phase = (model_phase + 1) % PERIOD;
        seen_en     = 1'b1;
      end
      outstanding = exp_data_q.size();
      cycle++;
    end
  end

  task automatic close_report();
    if (exp_data_q.size() != 0) begin
      protocol_errors += exp_data_q.size();
      $display("%0d expected IF samples never appeared", exp_data_q.size());
    end
    $display("Checker summary: %0d value errors, %0d protocol errors",
             value_errors, protocol_errors);
  endtask

endmodule

/* tests/iq_upconverter_tb.sv */
`timescale 1ns/1ps

module iq_upconverter_tb import iq_upconv_pkg::*;;

  localparam int PERIOD          = 4 * LUT_SIZE;
  localparam int RESET_CYCLES    = 8;
  localparam int POST_RESET_IDLE = 10;
  localparam int TONE_I_SAMPLES  = 2 * PERIOD;
  localparam int TONE_Q_SAMPLES  = PERIOD;
  localparam int RANDOM_CYCLES   = 256;
  localparam int SAT_SAMPLES     = PERIOD;
  localparam int BURST_SAMPLES   = 20;
  localparam int IDLE_TAIL       = 12;
  localparam int GAP             = 6;
  localparam int STIM_CYCLES     = RESET_CYCLES + POST_RESET_IDLE + TONE_I_SAMPLES
                                 + TONE_Q_SAMPLES + RANDOM_CYCLES + SAT_SAMPLES
                                 + BURST_SAMPLES + IDLE_TAIL + 4 * GAP;
  localparam int TIMEOUT_CYCLES  = STIM_CYCLES + 100;

  localparam int MAX_IN = 2 ** (DATA_W - 1) - 1;
  localparam int MIN_IN = -(2 ** (DATA_W - 1));

  logic                     clk;
  logic                     rstn;
  logic                     en;
  logic signed [DATA_W-1:0] i_data;
  logic signed [DATA_W-1:0] q_data;
  logic                     if_valid;
  logic signed [OUT_W-1:0]  if_data;

  int value_errors;
  int protocol_errors;
  int outstanding;
  int seed;
  int cycle_count = 0;

  iq_upconverter dut_i (
    .clk      (clk),
    .rstn     (rstn),
    .en       (en),
    .i_data   (i_data),
    .q_data   (q_data),
    .if_valid (if_valid),
    .if_data  (if_data)
  );

  iq_upconverter_checker chk_i (
    .clk             (clk),
    .rstn            (rstn),
    .en              (en),
    .i_data          (i_data),
    .q_data          (q_data),
    .if_valid        (if_valid),
    .if_data         (if_data),
    .value_errors    (value_errors),
    .protocol_errors (protocol_errors),
    .outstanding     (outstanding)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Run stopped after %0d cycles with %0d samples still in flight",
               cycle_count, outstanding);
      $display("Something failed");
      $finish;
    end
  end

  task automatic send_sample(input int i_val, input int q_val);
    @(negedge clk);
    en     = 1'b1;
    i_data = DATA_W'(i_val);
    q_data = DATA_W'(q_val);
  endtask

  // Junk on the data inputs while en is low.
  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      en     = 1'b0;
      i_data = DATA_W'($random(seed));
      q_data = DATA_W'($random(seed));
    end
  endtask

  task automatic send_constant(input int n, input int i_val, input int q_val);
    repeat (n) begin
      send_sample(i_val, q_val);
    end
  endtask

  task automatic random_traffic(input int n);
    repeat (n) begin
      @(negedge clk);
      en     = ($random(seed) & 32'd1) != 0;  // Low about half the time.
      i_data = DATA_W'($random(seed));
      q_data = DATA_W'($random(seed));
    end
  endtask

  task automatic send_burst(input int n);
    repeat (n) begin
      send_sample($random(seed), $random(seed));
    end
  endtask

  initial begin
    clk    = 1'b0;
    rstn   = 1'b0;
    en     = 1'b0;
    i_data = '0;
    q_data = '0;
    seed   = 45487;

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;

    idle_cycles(POST_RESET_IDLE);  // Outputs must stay quiet.

    // Two full periods of cosine, then a negated sine.
    send_constant(TONE_I_SAMPLES, MAX_IN, 0);
    idle_cycles(GAP);
    send_constant(TONE_Q_SAMPLES, 0, MAX_IN);
    idle_cycles(GAP);

    random_traffic(RANDOM_CYCLES);
    idle_cycles(GAP);

    // Large opposite inputs drive the output into both limits.
    send_constant(SAT_SAMPLES, MIN_IN, MAX_IN);
    idle_cycles(GAP);

    send_burst(BURST_SAMPLES);
    idle_cycles(IDLE_TAIL);

    while (outstanding != 0) begin
      @(negedge clk);
    end

    chk_i.close_report();
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* project.f */
logic/iq_upconv_pkg.sv
logic/sin_cos_iq_gen.sv
logic/iq_mixer.sv
logic/if_combiner.sv
logic/iq_upconverter.sv
tests/iq_upconverter_checker.sv
tests/iq_upconverter_tb.sv

/* Bender.yml */
package:
  name: iq_upconverter

sources:
  - logic/iq_upconv_pkg.sv
  - logic/sin_cos_iq_gen.sv
  - logic/iq_mixer.sv
  - logic/if_combiner.sv
  - logic/iq_upconverter.sv
  - target: test
    files:
      - tests/iq_upconverter_checker.sv
      - tests/iq_upconverter_tb.sv
